/* Makefile */
SIM       = verilator
TOP       = tb_dma
FILELIST  = all.f
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
common/dma_pkg.sv
common/mem_req_if.sv
design/mem_arbiter.sv
design/data_fifo.sv
dma_engine/read_src_fsm.sv
dma_engine/write_dest_fsm.sv
design/dma_top.sv
test/dma_chk.sv
test/tb_dma.sv

/* common/dma_pkg.sv */
// Shared widths, FIFO sizing, descriptor and status structs, and the FSM and opcode enums
// for the single-channel DMA engine.
`default_nettype none

package dma_pkg;

   localparam int data_w      = 32;
   localparam int addr_w      = 16;
   localparam int len_w       = 8;   // a length of zero is never issued.
   localparam int fifo_depth  = 8;
   localparam int fifo_ptr_w  = $clog2(fifo_depth);
   localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);
   localparam int perf_cntr_w = 16;

   // bit positions of the one-hot write engine states.
   localparam int num_wr_states     = 6;
   localparam int wr_idle_bit       = 0;
   localparam int wr_addr_setup_bit = 1;
   localparam int wr_fifo_empty_bit = 2;
   localparam int wr_dest_bit       = 3;
   localparam int wr_wait_rsp_bit   = 4;
   localparam int wr_error_bit      = 5;

   typedef struct packed {
      logic [addr_w-1:0] src_addr;
      logic [addr_w-1:0] dst_addr;
      logic [len_w-1:0]  length;
   } t_dma_descriptor;

   typedef enum logic {
      mem_read,
      mem_write
   } t_mem_op;

   typedef enum logic [num_wr_states-1:0] {
      wr_idle       = num_wr_states'(1) << wr_idle_bit,
      wr_addr_setup = num_wr_states'(1) << wr_addr_setup_bit,
      wr_fifo_empty = num_wr_states'(1) << wr_fifo_empty_bit,
      wr_dest       = num_wr_states'(1) << wr_dest_bit,
      wr_wait_rsp   = num_wr_states'(1) << wr_wait_rsp_bit,
      wr_error      = num_wr_states'(1) << wr_error_bit
   } t_wr_state;

   typedef enum logic [1:0] {
      rd_idle,
      rd_req,
      rd_wait_ack,
      rd_push
   } t_rd_state;

   typedef struct packed {
      logic                   busy;
      logic                   stopped_on_error;
      t_wr_state              wr_state;
      logic [perf_cntr_w-1:0] clk_cnt;    // active cycles of the current descriptor.
      logic [perf_cntr_w-1:0] valid_cnt;  // words written without error.
   } t_wr_status;

endpackage

`default_nettype wire

/* common/mem_req_if.sv */
// Four-phase memory requester port shared by the DMA engines and the arbiter.
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import dma_pkg::*; ();

   logic              req;
   t_mem_op           op;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;
   logic [data_w-1:0] rdata;  // valid while ack is high.
   logic              ack;
   logic              err;

   modport requester (
      output req,
      output op,
      output addr,
      output wdata,
      input  rdata,
      input  ack,
      input  err
   );

   modport arbiter (
      input  req,
      input  op,
      input  addr,
      input  wdata,
      output rdata,
      output ack,
      output err
   );

endinterface

`default_nettype wire

/* design/data_fifo.sv */
// Show-ahead synchronous FIFO between the read and write engines, with a one-cycle flush.
`timescale 1ns/1ps
`default_nettype none

module data_fifo import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  flush,
   input  logic                  push,
   input  logic [data_w-1:0]     push_data,
   input  logic                  pop,
   output logic [data_w-1:0]     pop_data,
   output logic                  not_empty,
   output logic [fifo_cnt_w-1:0] count
);

   logic [data_w-1:0]     mem [fifo_depth];
   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   assign not_empty = (count != '0);
   assign do_push   = push & (count != fifo_cnt_w'(fifo_depth));
   assign do_pop    = pop & not_empty;
   assign pop_data  = mem[rd_ptr];  // head word is visible before the pop.

   always_ff @(posedge clk) begin
      if (!reset_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
   end

endmodule

`default_nettype wire

/* design/dma_top.sv */
// DMA top level with the descriptor handshake and register, the two engines, the data FIFO
// and the memory arbiter.
`timescale 1ns/1ps
`default_nettype none

module dma_top import dma_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   desc_req,
   input  logic [addr_w-1:0]      desc_src,
   input  logic [addr_w-1:0]      desc_dst,
   input  logic [len_w-1:0]       desc_len,
   output logic                   desc_ack,
   output logic                   mem_req,
   output t_mem_op                mem_op,
   output logic [addr_w-1:0]      mem_addr,
   output logic [data_w-1:0]      mem_wdata,
   input  logic [data_w-1:0]      mem_rdata,
   input  logic                   mem_ack,
   input  logic                   mem_err,
   input  logic                   clear_error,
   output logic                   done,
   output logic                   busy,
   output logic                   error_flag,
   output logic [perf_cntr_w-1:0] perf_clk_cnt,
   output logic [perf_cntr_w-1:0] perf_valid_cnt
);

   t_dma_descriptor       desc_q;
   t_wr_status            wr_status;
   logic                  accept;
   logic                  start;    // one cycle after acceptance, desc_q is valid.
   logic                  flush;
   logic                  fifo_push;
   logic [data_w-1:0]     fifo_push_data;
   logic                  fifo_pop;
   logic [data_w-1:0]     fifo_pop_data;
   logic                  fifo_not_empty;
   logic [fifo_cnt_w-1:0] fifo_count;

   mem_req_if rd_if ();
   mem_req_if wr_if ();

   assign accept = desc_req & ~desc_ack & ~wr_status.busy;
   assign flush  = clear_error & wr_status.stopped_on_error;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         desc_ack <= 1'b0;
         start    <= 1'b0;
      end else begin
         start <= accept;
         if (accept)        desc_ack <= 1'b1;
         else if (!desc_req) desc_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) desc_q <= '{src_addr: desc_src, dst_addr: desc_dst, length: desc_len};
   end

   read_src_fsm u_read (
      .clk, .reset_n, .start, .flush, .desc(desc_q), .mem(rd_if.requester),
      .fifo_push, .fifo_push_data, .fifo_count
   );

   write_dest_fsm u_write (
      .clk, .reset_n, .start, .clear_error, .desc(desc_q), .fifo_pop,
      .fifo_data(fifo_pop_data), .fifo_not_empty, .mem(wr_if.requester),
      .done, .status(wr_status)
   );

   data_fifo u_fifo (
      .clk, .reset_n, .flush, .push(fifo_push), .push_data(fifo_push_data),
      .pop(fifo_pop), .pop_data(fifo_pop_data), .not_empty(fifo_not_empty),
      .count(fifo_count)
   );

   mem_arbiter u_arb (
      .clk, .reset_n, .rd_port(rd_if.arbiter), .wr_port(wr_if.arbiter),
      .mem_req, .mem_op, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack, .mem_err
   );

   assign busy           = wr_status.busy;
   assign error_flag     = wr_status.stopped_on_error;
   assign perf_clk_cnt   = wr_status.clk_cnt;
   assign perf_valid_cnt = wr_status.valid_cnt;

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
// Round-robin arbiter for the read and write engines on the shared four-phase memory port.
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import dma_pkg::*; (
   input  logic              clk,
   input  logic              reset_n,
   mem_req_if.arbiter        rd_port,
   mem_req_if.arbiter        wr_port,
   output logic              mem_req,
   output t_mem_op           mem_op,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   input  logic [data_w-1:0] mem_rdata,
   input  logic              mem_ack,
   input  logic              mem_err
);

   logic granted;   // a requester owns the memory port.
   logic grant_wr;  // the owner is the write engine.
   logic last_wr;   // the write engine was served last.
   logic any_req;
   logic pick_wr;
   logic owner_req;
   logic rd_sel;
   logic wr_sel;

   assign any_req   = rd_port.req | wr_port.req;
   assign pick_wr   = wr_port.req & (~rd_port.req | ~last_wr);
   assign owner_req = grant_wr ? wr_port.req : rd_port.req;
   assign rd_sel    = granted & ~grant_wr;
   assign wr_sel    = granted & grant_wr;

   // a new grant is only given once the previous ack has fallen.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         granted  <= 1'b0;
         grant_wr <= 1'b0;
         last_wr  <= 1'b1;
         mem_req  <= 1'b0;
      end else if (!granted) begin
         if (any_req && !mem_ack) begin
            granted  <= 1'b1;
            grant_wr <= pick_wr;
            last_wr  <= pick_wr;
            mem_req  <= 1'b1;
         end
      end else begin
         mem_req <= mem_req & owner_req;  // stays low once the owner has dropped req.
         if (!mem_req && !mem_ack) begin
            granted <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!granted && any_req && !mem_ack) begin
         mem_op    <= pick_wr ? wr_port.op : rd_port.op;
         mem_addr  <= pick_wr ? wr_port.addr : rd_port.addr;
         mem_wdata <= pick_wr ? wr_port.wdata : rd_port.wdata;
      end
   end

   assign rd_port.ack   = rd_sel & mem_ack;
   assign rd_port.err   = rd_sel & mem_err;
   assign rd_port.rdata = rd_sel ? mem_rdata : '0;
   assign wr_port.ack   = wr_sel & mem_ack;
   assign wr_port.err   = wr_sel & mem_err;
   assign wr_port.rdata = wr_sel ? mem_rdata : '0;

endmodule

`default_nettype wire

/* dma_engine/read_src_fsm.sv */
// Read engine that fetches source words through the arbiter and pushes them into the FIFO.
`timescale 1ns/1ps
`default_nettype none

module read_src_fsm import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  start,
   input  logic                  flush,
   input  t_dma_descriptor       desc,
   mem_req_if.requester          mem,
   output logic                  fifo_push,
   output logic [data_w-1:0]     fifo_push_data,
   input  logic [fifo_cnt_w-1:0] fifo_count
);

   t_rd_state           state;
   logic [addr_w-1:0]   src_addr;
   logic [len_w-1:0]    words_left;
   logic                pending;  // start arrived while a flushed read was still draining.
   logic                drop;     // the read in flight belongs to a flushed descriptor.
   logic                in_flight;
   logic [fifo_cnt_w:0] used;
   logic                has_room;

   assign in_flight = (state == rd_wait_ack);
   assign used      = fifo_count + in_flight;
   assign has_room  = (used < fifo_depth);

   assign mem.op    = mem_read;
   assign mem.addr  = src_addr;
   assign mem.wdata = '0;

   assign fifo_push      = in_flight & mem.ack & ~drop & ~flush;
   assign fifo_push_data = mem.rdata;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state      <= rd_idle;
         mem.req    <= 1'b0;
         words_left <= '0;
         pending    <= 1'b0;
         drop       <= 1'b0;
      end else begin
         if (start && state != rd_idle) pending <= 1'b1;
         unique case (state)
            rd_idle: if (start || pending) begin
               words_left <= desc.length;
               pending    <= 1'b0;
               state      <= rd_req;
            end
            rd_req: if (has_room) begin
               mem.req <= 1'b1;
               state   <= rd_wait_ack;
            end
            rd_wait_ack: if (mem.ack) begin
               mem.req <= 1'b0;
               if (!drop) words_left <= words_left - 1'b1;
               state   <= rd_push;
            end
            rd_push: if (!mem.ack) begin  // handshake closes before the next read.
               if (words_left == '0 || drop) begin
                  drop  <= 1'b0;
                  state <= rd_idle;
               end else begin
                  state <= rd_req;
               end
            end
            default: state <= rd_idle;
         endcase
         if (flush) begin
            words_left <= '0;
            if (in_flight) drop <= 1'b1;
            if (state == rd_req) begin
               mem.req <= 1'b0;
               state   <= rd_idle;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == rd_idle && (start || pending)) begin
         src_addr <= desc.src_addr;
      end else if (fifo_push) begin
         src_addr <= src_addr + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* dma_engine/write_dest_fsm.sv */
// Write engine with a one-hot FSM that drains the FIFO to the destination, tracks write
// responses and errors, and keeps per-descriptor performance counters.
`timescale 1ns/1ps
`default_nettype none

module write_dest_fsm import dma_pkg::*; (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              start,
   input  logic              clear_error,
   input  t_dma_descriptor   desc,
   output logic              fifo_pop,
   input  logic [data_w-1:0] fifo_data,
   input  logic              fifo_not_empty,
   mem_req_if.requester      mem,
   output logic              done,
   output t_wr_status        status
);

   t_wr_state              state;
   t_wr_state              next;
   logic [addr_w-1:0]      dst_addr;
   logic [len_w-1:0]       words_left;
   logic [perf_cntr_w-1:0] clk_cnt;
   logic [perf_cntr_w-1:0] valid_cnt;
   logic                   busy;
   logic                   wr_ok;      // write acked with err low.
   logic                   last_word;
   logic                   accept;

   assign accept    = state[wr_idle_bit] & start;
   assign wr_ok     = state[wr_wait_rsp_bit] & mem.ack & ~mem.err;
   assign last_word = (words_left == len_w'(1));
   assign done      = wr_ok & last_word;
   assign fifo_pop  = state[wr_dest_bit];
   assign mem.op    = mem_write;

   always_ff @(posedge clk) begin
      if (!reset_n) state <= wr_idle;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (1'b1)
         state[wr_idle_bit]:
            if (start) next = wr_addr_setup;
         state[wr_addr_setup_bit]:
            if (!mem.ack) next = wr_fifo_empty;  // the previous write's ack has fallen.
         state[wr_fifo_empty_bit]:
            if (fifo_not_empty) next = wr_dest;
         state[wr_dest_bit]:
            next = wr_wait_rsp;
         state[wr_wait_rsp_bit]:
            if (mem.ack) begin
               if (mem.err)        next = wr_error;
               else if (last_word) next = wr_idle;
               else                next = wr_addr_setup;
            end
         state[wr_error_bit]:
            if (clear_error) next = wr_idle;
         default:
            next = wr_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy       <= 1'b0;
         mem.req    <= 1'b0;
         words_left <= '0;
         clk_cnt    <= '0;
         valid_cnt  <= '0;
      end else begin
         if (accept) begin
            busy       <= 1'b1;
            words_left <= desc.length;
            clk_cnt    <= '0;
            valid_cnt  <= '0;
         end
         // active cycles exclude idle and a stop on error.
         if (!state[wr_idle_bit] && !state[wr_error_bit]) begin
            clk_cnt <= clk_cnt + 1'b1;
         end
         if (state[wr_dest_bit]) mem.req <= 1'b1;
         if (state[wr_wait_rsp_bit] && mem.ack) mem.req <= 1'b0;
         if (wr_ok) begin
            valid_cnt  <= valid_cnt + 1'b1;
            words_left <= words_left - 1'b1;
            if (last_word) busy <= 1'b0;
         end
         if (state[wr_error_bit] && clear_error) busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) dst_addr <= desc.dst_addr;
      else if (wr_ok) dst_addr <= dst_addr + 1'b1;
      if (state[wr_addr_setup_bit]) mem.addr <= dst_addr;
      if (state[wr_dest_bit]) mem.wdata <= fifo_data;  // head word, popped this cycle.
   end

   assign status.busy             = busy;
   assign status.stopped_on_error = state[wr_error_bit];
   assign status.wr_state         = state;
   assign status.clk_cnt          = clk_cnt;
   assign status.valid_cnt        = valid_cnt;

endmodule

`default_nettype wire

/* test/dma_chk.sv */
// Concurrent assertions on the memory and descriptor four-phase handshakes, bound to dma_top.
`timescale 1ns/1ps
`default_nettype none

module dma_chk (
   input logic clk,
   input logic reset_n,
   input logic desc_req,
   input logic desc_ack,
   input logic mem_req,
   input logic mem_ack,
   input logic rd_ack,
   input logic wr_ack
);

   req_held: assert property (@(posedge clk) disable iff (!reset_n)
      mem_req && !mem_ack |=> mem_req)
      else $error("mem_req fell before mem_ack rose");

   ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(mem_ack) |-> mem_req)
      else $error("mem_ack rose without mem_req");

   // each memory ack is routed to exactly one engine, the one holding the grant.
   ack_to_owner: assert property (@(posedge clk) disable iff (!reset_n)
      mem_ack |-> (rd_ack != wr_ack))
      else $error("mem_ack did not reach exactly one engine");

   desc_ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(desc_ack) |-> desc_req)
      else $error("desc_ack rose without desc_req");

endmodule

bind dma_top dma_chk u_chk (
   .clk(clk), .reset_n(reset_n), .desc_req(desc_req), .desc_ack(desc_ack),
   .mem_req(mem_req), .mem_ack(mem_ack), .rd_ack(rd_if.ack), .wr_ack(wr_if.ack)
);

`default_nettype wire

/* test/dma_vectors.txt */
# src dst len err_addr exp_valid, all hex; an err_addr of ffff injects no error.
# exp_valid is the number of words written without error before done or the error stop.
0010 1000 04 ffff 04
0100 2000 14 ffff 14
0200 3000 0c 3005 05
0300 4000 09 ffff 09
0400 5000 20 ffff 20
0030 1100 01 ffff 01
0500 6000 0a 6000 00
0600 7000 0b ffff 0b

/* test/tb_dma.sv */
// Testbench for the DMA engine with clock, reset, a memory model with random ack delay,
// the descriptor driver, the vector reader, the checks and the timeout.
`timescale 1ns/1ps
`default_nettype none

module tb_dma import dma_pkg::*; ();

   localparam int max_vectors = 32;
   localparam logic [data_w-1:0] fill_key = 32'hA5A5_0000;

   logic                   clk;
   logic                   reset_n;
   logic                   desc_req;
   logic [addr_w-1:0]      desc_src;
   logic [addr_w-1:0]      desc_dst;
   logic [len_w-1:0]       desc_len;
   logic                   desc_ack;
   logic                   mem_req;
   t_mem_op                mem_op;
   logic [addr_w-1:0]      mem_addr;
   logic [data_w-1:0]      mem_wdata;
   logic [data_w-1:0]      mem_rdata;
   logic                   mem_ack;
   logic                   mem_err;
   logic                   clear_error;
   logic                   done;
   logic                   busy;
   logic                   error_flag;
   logic [perf_cntr_w-1:0] perf_clk_cnt;
   logic [perf_cntr_w-1:0] perf_valid_cnt;

   logic [data_w-1:0] mem_model [0:65535];
   logic [addr_w-1:0] err_addr;           // a write here is answered with mem_err.
   logic [addr_w-1:0] vec_src [max_vectors];
   logic [addr_w-1:0] vec_dst [max_vectors];
   logic [len_w-1:0]  vec_len [max_vectors];
   logic [addr_w-1:0] vec_err [max_vectors];
   logic [len_w-1:0]  vec_valid [max_vectors];
   int                num_vectors;
   int                len_sum;
   int                cycle_limit = 0;
   int                cycle_cnt = 0;

   dma_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
      return data_w'(a) ^ fill_key;
   endfunction

   task automatic check_value(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic read_vectors();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_src;
      logic [31:0] f_dst;
      logic [31:0] f_len;
      logic [31:0] f_err;
      logic [31:0] f_valid;
      fd = $fopen("test/dma_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file test/dma_vectors.txt");
         $display("TESTS FAILED");
         $fatal(1, "no vectors");
      end
      num_vectors = 0;
      len_sum = 0;
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h", f_src, f_dst, f_len, f_err, f_valid);
            if (n == 5 && num_vectors < max_vectors) begin
               vec_src[num_vectors]   = f_src[addr_w-1:0];
               vec_dst[num_vectors]   = f_dst[addr_w-1:0];
               vec_len[num_vectors]   = f_len[len_w-1:0];
               vec_err[num_vectors]   = f_err[addr_w-1:0];
               vec_valid[num_vectors] = f_valid[len_w-1:0];
               len_sum += int'(f_len[len_w-1:0]);
               num_vectors++;
            end
         end
      end
      $fclose(fd);
   endtask

   // answers one four-phase transfer at a time after 0 to 3 idle cycles.
   initial begin : memory_model
      int unsigned delay;
      int          a;
      void'($urandom(32'h9462_3e4b));
      mem_rdata = '0;
      mem_ack   = 1'b0;
      mem_err   = 1'b0;
      for (a = 0; a < 65536; a++) mem_model[a] = fill_word(addr_w'(a));
      forever begin
         @(negedge clk);
         if (reset_n && mem_req && !mem_ack) begin
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            @(posedge clk);
            #2;
            if (mem_op == mem_write) begin
               if (mem_addr == err_addr) mem_err = 1'b1;  // the faulty word is not stored.
               else mem_model[mem_addr] = mem_wdata;
            end else begin
               mem_rdata = mem_model[mem_addr];
            end
            mem_ack = 1'b1;
            do @(negedge clk); while (mem_req);
            @(posedge clk);
            #2;
            mem_ack = 1'b0;
            mem_err = 1'b0;
         end
      end
   end

   task automatic run_vector(input int i);
      logic [addr_w-1:0] src;
      logic [addr_w-1:0] dst;
      logic [len_w-1:0]  len;
      logic              exp_err;
      int                k;
      src = vec_src[i];
      dst = vec_dst[i];
      len = vec_len[i];
      exp_err = (err_addr >= dst) && (err_addr < dst + addr_w'(len));
      @(negedge clk);
      check_value("desc_ack before desc_req", desc_ack, 0);
      @(posedge clk);
      #2;
      desc_req = 1'b1;
      desc_src = src;
      desc_dst = dst;
      desc_len = len;
      do @(negedge clk); while (!desc_ack);
      @(posedge clk);
      #2;
      desc_req = 1'b0;
      @(negedge clk);
      check_value("desc_ack still high", desc_ack, 1);
      @(negedge clk);
      check_value("desc_ack one cycle after desc_req fell", desc_ack, 0);
      check_value("busy after acceptance", busy, 1);
      while (!done && !error_flag) begin
         @(negedge clk);
         check_value("busy during transfer", busy, 1);
      end
      check_value("error_flag at end of transfer", error_flag, exp_err);
      if (!exp_err) begin
         @(negedge clk);
         check_value("busy after done", busy, 0);
         check_value("perf_valid_cnt", perf_valid_cnt, vec_valid[i]);
         check_value("perf_clk_cnt not below len", perf_clk_cnt >= perf_cntr_w'(len), 1);
         for (k = 0; k < len; k++) begin
            check_value("copied word", mem_model[addr_w'(dst + k)], fill_word(addr_w'(src + k)));
         end
         check_value("word below range", mem_model[addr_w'(dst - 1)], fill_word(dst - 1'b1));
         check_value("word above range", mem_model[addr_w'(dst + len)],
                     fill_word(dst + addr_w'(len)));
      end else begin
         repeat (10) begin
            @(negedge clk);
            check_value("done while stopped on error", done, 0);
            check_value("busy while stopped on error", busy, 1);
            check_value("error_flag held", error_flag, 1);
         end
         check_value("perf_valid_cnt before error", perf_valid_cnt, vec_valid[i]);
         for (k = 0; k < vec_valid[i]; k++) begin
            check_value("copied word", mem_model[addr_w'(dst + k)], fill_word(addr_w'(src + k)));
         end
         check_value("word at error address", mem_model[err_addr], fill_word(err_addr));
         @(posedge clk);
         #2;
         clear_error = 1'b1;
         @(posedge clk);
         #2;
         clear_error = 1'b0;
         @(negedge clk);
         check_value("error_flag after clear", error_flag, 0);
         check_value("busy after clear", busy, 0);
      end
   endtask

   initial begin : main
      int i;
      reset_n     = 1'b0;
      desc_req    = 1'b0;
      desc_src    = '0;
      desc_dst    = '0;
      desc_len    = '0;
      clear_error = 1'b0;
      err_addr    = '1;
      read_vectors();
      cycle_limit = 200 + 40 * len_sum;
      repeat (2) @(posedge clk);
      #2;
      reset_n = 1'b1;
      @(negedge clk);
      check_value("desc_ack after reset", desc_ack, 0);
      check_value("mem_req after reset", mem_req, 0);
      check_value("done after reset", done, 0);
      check_value("busy after reset", busy, 0);
      check_value("error_flag after reset", error_flag, 0);
      for (i = 0; i < num_vectors; i++) begin
         err_addr = vec_err[i];
         run_vector(i);
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
